// File: cart_slot.f
+incdir+sim
common/msx_bus_pkg.sv
common/mapper_pkg.sv
mappers/mapper_ascii8.sv
mappers/mapper_ascii16.sv
mappers/mapper_konami.sv
mappers/mapper_offset.sv
mappers/mappers.sv
verilog/cart_slot.sv
sim/tb_cart_slot.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cartridge slot testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=run.log

verilator --binary --assert --timescale 1ns/1ns --top-module tb_cart_slot \
    -f cart_slot.f -Mdir obj_dir -o tb_cart_slot \
    && ./obj_dir/tb_cart_slot > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "build or simulation error"; exit 1; }

cat "$LOG"
grep -q "SOME TESTS FAILED" "$LOG" && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" "$LOG" || { echo "no verdict in log"; exit 1; }
echo "simulation passed"
exit 0

// File: sim/cart_model.svh
`ifndef CART_MODEL_SVH
`define CART_MODEL_SVH

mapper_cfg_t model_cfg;           // Configuration as the slot register holds it
logic [7:0]  model_a8  [0:3];     // ASCII8 banks per 8 KB window
logic [7:0]  model_a16 [0:1];     // ASCII16 banks, low and high 16 KB window
logic [7:0]  model_kon [0:3];     // Konami banks, entry 0 is the fixed bank

function automatic void model_reset();
    model_cfg = '{typ: MAPPER_NONE, rom_mask: 8'h00, offset: 8'h00};
    model_a8  = '{default: 8'h00};
    model_a16 = '{default: 8'h00};
    model_kon = '{8'd0, 8'd1, 8'd2, 8'd3};   // Konami power up layout
endfunction

// Expected memory bus for one CPU access with the current model state
function automatic memory_bus_t model_expect(input cpu_bus_t c);
    memory_bus_t e;
    int          a;
    logic [1:0]  w;        // 8 KB window, 0 at 0x4000
    int          bank;     // Bank after the ROM mask
    int          rom;
    int          sram_a;
    logic        sram;
    e      = '{addr: '1, rnw: 1'b1, ram_cs: 1'b0, sram_cs: 1'b0};
    a      = int'(c.addr);
    w      = 2'((a - 'h4000) / 'h2000);
    sram_a = a % (1 << SRAM_W);                 // SRAM_W from the testbench
    sram   = 1'b0;
    rom    = 0;
    if (a < 'h4000 || a > 'hBFFF || !(c.rd || c.wr)) begin
        return e;                               // Outside the slot or no strobe
    end
    case (model_cfg.typ)
        MAPPER_ASCII8: begin
            bank = int'(model_a8[w]) & int'(model_cfg.rom_mask);
            sram = model_a8[w][7] && w[1];       // Upper two windows only
            rom  = bank * 'h2000 + a % 'h2000;
        end
        MAPPER_ASCII16: begin
            bank = int'(model_a16[w[1]]) & int'(model_cfg.rom_mask);
            sram = model_a16[w[1]][7] && w[1];
            rom  = bank * 'h4000 + a % 'h4000;
        end
        MAPPER_KONAMI: begin
            bank = int'(model_kon[w]) & int'(model_cfg.rom_mask);
            rom  = bank * 'h2000 + a % 'h2000;
        end
        MAPPER_OFFSET: rom = int'(model_cfg.offset) * 'h4000 + a - 'h4000;
        default:       return e;
    endcase
    if (c.rd) begin                             // Read has priority
        e.addr    = sram ? sram_a[MEM_ADDR_W-1:0] : rom[MEM_ADDR_W-1:0];
        e.ram_cs  = !sram;
        e.sram_cs = sram;
    end else if (sram) begin                    // Battery RAM write
        e.addr    = sram_a[MEM_ADDR_W-1:0];
        e.rnw     = 1'b0;
        e.sram_cs = 1'b1;
    end
    return e;
endfunction

// State change at the clock edge, bank writes then the config register
function automatic void model_clock(input cpu_bus_t c, input mapper_cfg_t f);
    int a;
    a = int'(c.addr);
    if (c.wr && model_cfg.typ == MAPPER_ASCII8 && a >= 'h6000 && a < 'h8000) begin
        model_a8[2'((a - 'h6000) / 'h800)] = c.data;     // 2 KB per register
    end
    if (c.wr && model_cfg.typ == MAPPER_ASCII16 && a >= 'h6000 && a < 'h6800) begin
        model_a16[0] = c.data;
    end
    if (c.wr && model_cfg.typ == MAPPER_ASCII16 && a >= 'h7000 && a < 'h7800) begin
        model_a16[1] = c.data;
    end
    if (c.wr && model_cfg.typ == MAPPER_KONAMI && a >= 'h6000 && a < 'hC000) begin
        model_kon[2'((a - 'h4000) / 'h2000)] = c.data;   // Window written sets its bank
    end
    model_cfg = f;                              // Config change one cycle late
endfunction

task automatic model_step(input cpu_bus_t c, input mapper_cfg_t f,
                          output memory_bus_t e);
    e = model_expect(c);
    model_clock(c, f);
endtask

`endif

// File: sim/tb_cart_slot.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cart_slot;
    import msx_bus_pkg::*;
    import mapper_pkg::*;

    localparam int SRAM_W       = 13;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int ITERS        = 100;    // Loops of the directed bank tests
    localparam int MIX_CYCLES   = 2000;
    // Idle 120, ascii8 5 per loop, ascii16 6, konami 5, three settle cycles, offset 300
    localparam int TOTAL_CYCLES = RESET_CYCLES + 120 + 16 * ITERS + 3 + 300 + MIX_CYCLES;
    localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 100) * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        reset;
    cpu_bus_t    cpu;
    mapper_cfg_t cfg;
    memory_bus_t mem;

    integer seed = 32'h9c7;
    int test_errs;                        // Mismatches in the running test
    int test_cycles;
    int tests_run;
    int tests_failed;
    int err_total;

    cart_slot #(.SRAM_ADDR_W(SRAM_W)) UUT (
        .clk(clk), .reset(reset), .cpu(cpu), .cfg(cfg), .mem(mem)
    );

    `include "cart_model.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_random();
        next_random = $random(seed);
    endfunction

    function automatic cpu_bus_t make_cpu(input logic [15:0] a, input logic [7:0] d,
                                          input logic r, input logic w);
        make_cpu = '{addr: a, data: d, rd: r, wr: w};
    endfunction

    // Random address inside 8 KB window w, counted from 0x4000
    function automatic logic [15:0] win_addr(input logic [1:0] w, input logic [31:0] r);
        win_addr = {{1'b0, w} + 3'd2, r[12:0]};
    endfunction

    function automatic mapper_type_t pick_type(input logic [31:0] r);
        case (r % 32'd5)
            32'd0:   pick_type = MAPPER_NONE;
            32'd1:   pick_type = MAPPER_OFFSET;
            32'd2:   pick_type = MAPPER_ASCII8;
            32'd3:   pick_type = MAPPER_ASCII16;
            default: pick_type = MAPPER_KONAMI;
        endcase
    endfunction

    task automatic check_bus(input memory_bus_t e);
        if (mem.addr !== e.addr) begin
            $display("ERR %0t mem.addr expected %h got %h", $time, e.addr, mem.addr);
            test_errs++;
        end
        if (mem.rnw !== e.rnw) begin
            $display("ERR %0t mem.rnw expected %b got %b", $time, e.rnw, mem.rnw);
            test_errs++;
        end
        if (mem.ram_cs !== e.ram_cs) begin
            $display("ERR %0t mem.ram_cs expected %b got %b", $time, e.ram_cs, mem.ram_cs);
            test_errs++;
        end
        if (mem.sram_cs !== e.sram_cs) begin
            $display("ERR %0t mem.sram_cs expected %b got %b", $time, e.sram_cs, mem.sram_cs);
            test_errs++;
        end
    endtask

    // Drive 1 ns after the edge, compare just before the next one
    task automatic run_cycle(input cpu_bus_t c, input mapper_cfg_t f);
        memory_bus_t e;
        cpu = c;
        cfg = f;
        #(CLK_PERIOD - 2);
        model_step(c, f, e);
        check_bus(e);
        test_cycles++;
        @(posedge clk);
        #1;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s passed, %0d cycles", name, test_cycles);
        end else begin
            $display("test %s failed, %0d mismatches", name, test_errs);
            tests_failed++;
            err_total += test_errs;
        end
        test_errs   = 0;
        test_cycles = 0;
    endtask

    initial begin
        logic [31:0] r;
        mapper_cfg_t f;
        int          i;
        int          w;
        reset = 1'b1;
        cpu   = '0;
        cfg   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        model_reset();

        // Empty slot, quiet first and then random strobes
        f = '0;
        for (i = 0; i < 120; i++) begin
            r = next_random();
            f.rom_mask = r[31:24];
            run_cycle(make_cpu(r[15:0], r[23:16], i >= 20 && r[16], i >= 20 && r[17]), f);
        end
        end_test("reset and idle");

        f = '{typ: MAPPER_ASCII8, rom_mask: 8'hFF, offset: 8'h00};
        run_cycle(make_cpu(16'h0000, 8'h00, 1'b0, 1'b0), f);    // Type lands at the edge
        for (i = 0; i < ITERS; i++) begin
            r = next_random();
            run_cycle(make_cpu({3'b011, r[12:0]}, {1'b0, r[22:16]}, 1'b0, 1'b1), f);
            for (w = 0; w < 4; w++) begin
                r = next_random();
                run_cycle(make_cpu(win_addr(w[1:0], r), r[23:16], 1'b1, 1'b0), f);
            end
        end
        end_test("ascii8 switching");

        f = '{typ: MAPPER_ASCII16, rom_mask: 8'h0F, offset: 8'h00};
        run_cycle(make_cpu(16'h0000, 8'h00, 1'b0, 1'b0), f);
        for (i = 0; i < ITERS; i++) begin
            r = next_random();
            if (i == ITERS / 2) begin
                f.rom_mask = 8'hFF;                                  // Larger ROM
            end
            run_cycle(make_cpu({5'b01100, r[10:0]}, r[23:16], 1'b0, 1'b1), f);  // Bank 0
            run_cycle(make_cpu({5'b01110, r[10:0]}, r[31:24], 1'b0, 1'b1), f);  // Bank 1
            run_cycle(make_cpu({2'b01, r[13:0]}, 8'h00, 1'b1, 1'b0), f);
            run_cycle(make_cpu({2'b10, r[13:0]}, 8'h00, 1'b1, 1'b0), f);
            run_cycle(make_cpu({2'b10, r[15:2]}, r[23:16], 1'b0, 1'b1), f);  // SRAM if bit 7
            run_cycle(make_cpu({3'b010, r[12:0]}, r[23:16], 1'b0, 1'b1), f); // ROM, dropped
        end
        end_test("ascii16 and sram");

        f = '{typ: MAPPER_KONAMI, rom_mask: 8'hFF, offset: 8'h00};
        run_cycle(make_cpu(16'h0000, 8'h00, 1'b0, 1'b0), f);
        for (i = 0; i < ITERS; i++) begin
            r = next_random();
            run_cycle(make_cpu(win_addr(r[14:13], r), r[23:16], 1'b0, 1'b1), f);
            for (w = 0; w < 4; w++) begin
                r = next_random();
                run_cycle(make_cpu(win_addr(w[1:0], r), 8'h00, 1'b1, 1'b0), f);
            end
        end
        end_test("konami");

        // Linear reads, then every type outside 0x4000 - 0xBFFF
        for (i = 0; i < 300; i++) begin
            r = next_random();
            if (i < 100) begin
                if (i % 10 == 0) begin
                    f = '{typ: MAPPER_OFFSET, rom_mask: 8'hFF, offset: r[31:24]};
                end
                run_cycle(make_cpu({r[15] ? 2'b10 : 2'b01, r[13:0]}, 8'h00, 1'b1, 1'b0), f);
            end else begin
                f = '{typ: pick_type(r), rom_mask: r[31:24], offset: r[23:16]};
                run_cycle(make_cpu({r[15] ? 2'b11 : 2'b00, r[13:0]}, r[23:16], r[16], r[17]), f);
            end
        end
        end_test("offset and out of range");

        f = '{typ: MAPPER_ASCII8, rom_mask: 8'hFF, offset: 8'h00};
        for (i = 0; i < MIX_CYCLES; i++) begin
            r = next_random();
            if (r[4:0] == 5'd0) begin                               // Rare type change
                f = '{typ: pick_type(r), rom_mask: r[15:8], offset: r[23:16]};
            end
            r = next_random();
            run_cycle(make_cpu(r[20] ? {3'b011, r[12:0]} : r[15:0], r[31:24], r[21], r[22]), f);
        end
        end_test("random mix");

        $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, err_total);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Hang guard sized from the cycle count of all tests
    initial begin
        #(WATCHDOG_NS);
        $display("timeout, simulation still running after %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/cart_slot.sv
`timescale 1ns/1ns
`default_nettype none

// Cartridge slot top, configuration register in front of the mapper combiner
module cart_slot #(
    parameter int SRAM_ADDR_W = 13                  // 13 for 8 KB, 11 for 2 KB
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire msx_bus_pkg::cpu_bus_t   cpu,
    input  wire mapper_pkg::mapper_cfg_t cfg,
    output msx_bus_pkg::memory_bus_t     mem
);
    import mapper_pkg::*;

    mapper_cfg_t cfg_q;   // Configuration seen by all mappers

    // Mapper change lands on a clock edge, one cycle late
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_q <= MAPPER_CFG_RESET;   // No mapper after reset
        end else begin
            cfg_q <= cfg;
        end
    end

    mappers #(
        .SRAM_ADDR_W(SRAM_ADDR_W)
    ) mappers (
        .clk   (clk),
        .reset (reset),
        .cpu   (cpu),      // CPU access goes straight through, same cycle
        .cfg   (cfg_q),
        .mem   (mem)
    );

endmodule

`default_nettype wire

// File: mappers/mappers.sv
`timescale 1ns/1ns
`default_nettype none

// Mapper combiner, every mapper runs and the unselected ones sit idle
module mappers #(
    parameter int SRAM_ADDR_W = 13
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire msx_bus_pkg::cpu_bus_t   cpu,
    input  wire mapper_pkg::mapper_cfg_t cfg,
    output msx_bus_pkg::memory_bus_t     mem
);
    import msx_bus_pkg::*;
    import mapper_pkg::*;

    mapper_out_t ascii8_out;    // Per mapper contributions
    mapper_out_t ascii16_out;
    mapper_out_t konami_out;
    mapper_out_t offset_out;

    mapper_ascii8 #(.SRAM_ADDR_W(SRAM_ADDR_W)) ascii8 (
        .clk(clk), .reset(reset), .cpu(cpu), .cfg(cfg), .out(ascii8_out)
    );

    mapper_ascii16 #(.SRAM_ADDR_W(SRAM_ADDR_W)) ascii16 (
        .clk(clk), .reset(reset), .cpu(cpu), .cfg(cfg), .out(ascii16_out)
    );

    mapper_konami konami (
        .clk(clk), .reset(reset), .cpu(cpu), .cfg(cfg), .out(konami_out)
    );

    mapper_offset offset (
        .cpu(cpu), .cfg(cfg), .out(offset_out)
    );

    // Idle mappers give all ones, so AND leaves the active one
    assign mem.addr = ascii8_out.addr & ascii16_out.addr
                    & konami_out.addr & offset_out.addr;
    assign mem.rnw  = ascii8_out.rnw & ascii16_out.rnw
                    & konami_out.rnw & offset_out.rnw;

    // Selects are zero when idle, OR collects them
    assign mem.ram_cs  = ascii8_out.ram_cs | ascii16_out.ram_cs
                       | konami_out.ram_cs | offset_out.ram_cs;
    assign mem.sram_cs = ascii8_out.sram_cs | ascii16_out.sram_cs
                       | konami_out.sram_cs | offset_out.sram_cs;

    // Only one chip on the memory bus at a time
    cs_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem.ram_cs && mem.sram_cs));

    // Empty slot stays silent whatever the CPU does
    none_is_idle: assert property (@(posedge clk) disable iff (reset)
        cfg.typ == MAPPER_NONE |-> !mem.ram_cs && !mem.sram_cs);

endmodule

`default_nettype wire

// File: mappers/mapper_offset.sv
`timescale 1ns/1ns
`default_nettype none

// Linear ROM, 0x4000 maps to the configured start
module mapper_offset (
    input  wire msx_bus_pkg::cpu_bus_t   cpu,
    input  wire mapper_pkg::mapper_cfg_t cfg,
    output mapper_pkg::mapper_out_t      out
);
    import msx_bus_pkg::*;
    import mapper_pkg::*;

    logic        sel;
    logic        in_range;
    logic [1:0]  page;       // Page relative to 0x4000
    logic [21:0] lin_addr;   // Offset * 16 KB + (addr - 0x4000)

    assign sel      = cfg.typ == MAPPER_OFFSET;
    assign in_range = cpu.addr[15:14] == PAGE_1 || cpu.addr[15:14] == PAGE_2;
    assign page     = cpu.addr[15:14] - 2'd1;
    assign lin_addr = {cfg.offset, 14'h0000} + {6'd0, page, cpu.addr[13:0]};

    always_comb begin
        out = MAPPER_IDLE;
        if (sel && in_range && cpu.rd) begin       // Reads only
            out.addr   = lin_addr[MEM_ADDR_W-1:0];
            out.ram_cs = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: mappers/mapper_konami.sv
`timescale 1ns/1ns
`default_nettype none

// Konami mapper without SCC, first 8 KB window fixed
module mapper_konami (
    input  wire                       clk,
    input  wire                       reset,
    input  wire msx_bus_pkg::cpu_bus_t   cpu,
    input  wire mapper_pkg::mapper_cfg_t cfg,
    output mapper_pkg::mapper_out_t      out
);
    import msx_bus_pkg::*;
    import mapper_pkg::*;

    logic [3:1][7:0] bank;      // Switchable banks for 0x6000 0x8000 0xA000
    logic            sel;
    logic            in_range;
    logic [1:0]      win;       // Window index, 0 is the fixed one
    logic            reg_we;
    logic [7:0]      bank_cur;
    logic [20:0]     rom_addr;

    assign sel      = cfg.typ == MAPPER_KONAMI;
    assign in_range = cpu.addr[15:14] == PAGE_1 || cpu.addr[15:14] == PAGE_2;
    assign win      = {~cpu.addr[14], cpu.addr[13]};

    // Any write into a switchable window sets its bank
    assign reg_we   = sel && cpu.wr && in_range && win != 2'd0;

    always_comb begin
        case (win)
            2'd1:    bank_cur = bank[1];
            2'd2:    bank_cur = bank[2];
            2'd3:    bank_cur = bank[3];
            default: bank_cur = 8'h00;     // 0x4000 always bank 0
        endcase
    end

    assign rom_addr = {bank_cur & cfg.rom_mask, cpu.addr[12:0]};

    // Power up layout is banks 0 1 2 3
    always_ff @(posedge clk) begin
        if (reset) begin
            bank <= {8'd3, 8'd2, 8'd1};
        end else if (reg_we) begin
            bank[win] <= cpu.data;
        end
    end

    // ROM only, writes never reach memory
    always_comb begin
        out = MAPPER_IDLE;
        if (sel && in_range && cpu.rd) begin
            out.addr   = rom_addr[MEM_ADDR_W-1:0];
            out.ram_cs = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: mappers/mapper_ascii16.sv
`timescale 1ns/1ns
`default_nettype none

// ASCII16 mapper with two 16 KB windows
module mapper_ascii16 #(
    parameter int SRAM_ADDR_W = 13                  // SRAM size in address bits
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire msx_bus_pkg::cpu_bus_t   cpu,
    input  wire mapper_pkg::mapper_cfg_t cfg,
    output mapper_pkg::mapper_out_t      out
);
    import msx_bus_pkg::*;
    import mapper_pkg::*;

    logic [1:0][7:0]       bank;       // Bank for 0x4000 and 0x8000 windows
    logic                  sel;
    logic                  in_range;
    logic                  reg_we;
    logic                  win;        // 0 low window, 1 high window
    logic [7:0]            bank_cur;
    logic                  is_sram;
    logic [21:0]           rom_addr;   // Full 8 bit bank reach, cut to bus width
    logic [MEM_ADDR_W-1:0] sram_addr;

    assign sel      = cfg.typ == MAPPER_ASCII16;
    assign in_range = cpu.addr[15:14] == PAGE_1 || cpu.addr[15:14] == PAGE_2;

    // 0x6000 - 0x67FF and 0x7000 - 0x77FF, the 0x_800 halves are ignored
    assign reg_we   = sel && cpu.wr && cpu.addr[15:13] == 3'b011 && !cpu.addr[11];

    assign win      = cpu.addr[15];
    assign bank_cur = bank[win];
    assign is_sram  = bank_cur[7] && win;          // Bank 0 with bit 7 stays ROM

    assign rom_addr  = {bank_cur & cfg.rom_mask, cpu.addr[13:0]};
    assign sram_addr = {{(MEM_ADDR_W-SRAM_ADDR_W){1'b0}}, cpu.addr[SRAM_ADDR_W-1:0]};

    // addr[12] picks the register
    always_ff @(posedge clk) begin
        if (reset) begin
            bank <= '0;
        end else if (reg_we) begin
            bank[cpu.addr[12]] <= cpu.data;
        end
    end

    always_comb begin
        out = MAPPER_IDLE;
        if (sel && in_range) begin
            if (cpu.rd) begin
                if (is_sram) begin
                    out.addr    = sram_addr;
                    out.sram_cs = 1'b1;
                end else begin
                    out.addr   = rom_addr[MEM_ADDR_W-1:0];
                    out.ram_cs = 1'b1;
                end
            end else if (cpu.wr && is_sram) begin
                // Register range lies in window 0 so never lands here
                out.addr    = sram_addr;
                out.rnw     = 1'b0;
                out.sram_cs = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: mappers/mapper_ascii8.sv
`timescale 1ns/1ns
`default_nettype none

// ASCII8 mapper with four 8 KB windows
module mapper_ascii8 #(
    parameter int SRAM_ADDR_W = 13                  // SRAM size in address bits
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire msx_bus_pkg::cpu_bus_t   cpu,
    input  wire mapper_pkg::mapper_cfg_t cfg,
    output mapper_pkg::mapper_out_t      out
);
    import msx_bus_pkg::*;
    import mapper_pkg::*;

    logic [3:0][7:0]       bank;       // Bank per window at 0x4000 0x6000 0x8000 0xA000
    logic                  sel;        // ASCII8 is the configured mapper
    logic                  in_range;   // Access inside 0x4000 - 0xBFFF
    logic                  reg_we;     // Bank register write this cycle
    logic [1:0]            win;        // Window of the current access
    logic [7:0]            bank_cur;   // Bank seen by the current access
    logic                  is_sram;    // Current window maps SRAM
    logic [20:0]           rom_addr;
    logic [MEM_ADDR_W-1:0] sram_addr;

    assign sel      = cfg.typ == MAPPER_ASCII8;
    assign in_range = cpu.addr[15:14] == PAGE_1 || cpu.addr[15:14] == PAGE_2;
    assign reg_we   = sel && cpu.wr && cpu.addr[15:13] == 3'b011;  // 0x6000 - 0x7FFF

    // 0x4000 -> 0, 0x6000 -> 1, 0x8000 -> 2, 0xA000 -> 3
    assign win      = {~cpu.addr[14], cpu.addr[13]};
    assign bank_cur = bank[win];
    assign is_sram  = bank_cur[7] && win[1];      // Only upper two windows hold SRAM

    assign rom_addr  = {bank_cur & cfg.rom_mask, cpu.addr[12:0]};
    assign sram_addr = {{(MEM_ADDR_W-SRAM_ADDR_W){1'b0}}, cpu.addr[SRAM_ADDR_W-1:0]};

    // Bank select with the register index from addr[12:11]
    always_ff @(posedge clk) begin
        if (reset) begin
            bank <= '0;
        end else if (reg_we) begin
            bank[cpu.addr[12:11]] <= cpu.data;
        end
    end

    // Read wins over write when both strobes are up
    always_comb begin
        out = MAPPER_IDLE;
        if (sel && in_range) begin
            if (cpu.rd) begin
                if (is_sram) begin
                    out.addr    = sram_addr;
                    out.sram_cs = 1'b1;
                end else begin
                    out.addr   = rom_addr[MEM_ADDR_W-1:0];
                    out.ram_cs = 1'b1;
                end
            end else if (cpu.wr && is_sram) begin
                out.addr    = sram_addr;   // Battery RAM write
                out.rnw     = 1'b0;
                out.sram_cs = 1'b1;
            end
        end
    end

    // Banks move only after an ASCII8 CPU write into 0x6000 - 0x7FFF
    bank_write_only: assert property (@(posedge clk) disable iff (reset)
        !$stable(bank) |-> $past(cpu.wr && cpu.addr >= 16'h6000 && cpu.addr <= 16'h7FFF
                                 && cfg.typ == MAPPER_ASCII8));

endmodule

`default_nettype wire

// File: common/mapper_pkg.sv
`default_nettype none

// Mapper selection and per mapper output format
package mapper_pkg;

    // Mapper kinds supported in this slot
    typedef enum logic [2:0] {
        MAPPER_NONE    = 3'd0,   // Slot empty, never answers
        MAPPER_OFFSET  = 3'd1,   // Plain linear ROM
        MAPPER_ASCII8  = 3'd2,   // Four 8 KB banks, SRAM capable
        MAPPER_ASCII16 = 3'd3,   // Two 16 KB banks, SRAM capable
        MAPPER_KONAMI  = 3'd4    // Konami without SCC
    } mapper_type_t;

    // Cartridge configuration
    typedef struct packed {
        mapper_type_t typ;       // Selected mapper
        logic [7:0]   rom_mask;  // Bank number AND mask, follows ROM size
        logic [7:0]   offset;    // Offset mapper start in 16 KB units
    } mapper_cfg_t;

    // What a single mapper hands to the combiner
    // Same layout as the memory bus so merging is field by field
    typedef struct packed {
        logic [msx_bus_pkg::MEM_ADDR_W-1:0] addr;
        logic                               rnw;
        logic                               ram_cs;
        logic                               sram_cs;
    } mapper_out_t;

    // Neutral value for AND/OR merging
    // Driven by every mapper that is not selected or has nothing to do
    parameter mapper_out_t MAPPER_IDLE = '{
        addr:    {msx_bus_pkg::MEM_ADDR_W{1'b1}},
        rnw:     1'b1,
        ram_cs:  1'b0,
        sram_cs: 1'b0
    };

    // Configuration after reset, no mapper
    parameter mapper_cfg_t MAPPER_CFG_RESET = '{
        typ:      MAPPER_NONE,
        rom_mask: 8'h00,
        offset:   8'h00
    };

endpackage

`default_nettype wire

// File: common/msx_bus_pkg.sv
`default_nettype none

// Bus formats on both sides of the cartridge slot
package msx_bus_pkg;

    // Memory side address width, 2 MB of ROM space
    parameter int MEM_ADDR_W = 21;

    // One Z80 access as seen on the cartridge connector
    typedef struct packed {
        logic [15:0] addr;   // CPU address
        logic [7:0]  data;   // Write data, used for bank writes
        logic        rd;     // Read strobe
        logic        wr;     // Write strobe
    } cpu_bus_t;

    // Access towards ROM and SRAM chips
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] addr;     // Linear memory address
        logic                  rnw;      // High for read
        logic                  ram_cs;   // ROM/RAM select
        logic                  sram_cs;  // Battery backed SRAM select
    } memory_bus_t;

    // Idle memory bus
    // All ones on addr and rnw so that AND merging keeps the other side
    parameter memory_bus_t MEM_BUS_IDLE = '{
        addr:    {MEM_ADDR_W{1'b1}},
        rnw:     1'b1,
        ram_cs:  1'b0,
        sram_cs: 1'b0
    };

    // Cartridge window on the CPU side is pages 1 and 2
    parameter logic [1:0] PAGE_1 = 2'b01;   // 0x4000 - 0x7FFF
    parameter logic [1:0] PAGE_2 = 2'b10;   // 0x8000 - 0xBFFF

endpackage

`default_nettype wire
